// ==== common/exec_pkg.sv ====
// Shared types for the execute stage of a 32-bit RISC-V core
// Operation codes come already decoded from the previous stage
// Exception codes follow the RISC-V mcause numbering, NE marks "no exception"
`default_nettype none

package exec_pkg;

    localparam int WORD_W = 32;

    // Return address increments for JAL/JALR
    localparam logic [WORD_W-1:0] LINK_STEP_FULL       = 32'd4;
    localparam logic [WORD_W-1:0] LINK_STEP_COMPRESSED = 32'd2;

    typedef enum logic [5:0] {
        NOP, ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, LUI,
        LB, LBU, LH, LHU, LW, SB, SH, SW,
        BEQ, BNE, BLT, BLTU, BGE, BGEU, JAL, JALR,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
        ECALL, EBREAK, MRET
    } op_e;

    typedef enum logic [1:0] {
        NONE, WRITE, SET, CLEAR
    } csr_op_e;

    // Encoded like CSR address bits 9:8
    typedef enum logic [1:0] {
        USER    = 2'b00,
        MACHINE = 2'b11
    } priv_e;

    typedef enum logic [3:0] {
        INSTRUCTION_ADDRESS_MISALIGNED = 4'd0,
        INSTRUCTION_ACCESS_FAULT       = 4'd1,
        ILLEGAL_INSTRUCTION            = 4'd2,
        BREAKPOINT                     = 4'd3,
        LOAD_ACCESS_FAULT              = 4'd5,
        ECALL_FROM_UMODE               = 4'd8,
        ECALL_FROM_MMODE               = 4'd11,
        NE                             = 4'd15
    } exc_code_e;

    // Instruction as issued into the stage
    typedef struct packed {
        op_e               op;
        logic [WORD_W-1:0] pc;
        logic [WORD_W-1:0] first_operand;
        logic [WORD_W-1:0] second_operand;
        logic [WORD_W-1:0] third_operand;
        logic              compressed;
        logic [WORD_W-1:0] instruction;
    } exec_in_t;

    typedef struct packed {
        logic [WORD_W-1:0] address;
        logic              read_enable;
        logic [3:0]        write_enable;
        logic [WORD_W-1:0] write_data;
    } mem_req_t;

    typedef struct packed {
        logic [11:0]       address;
        logic              read_enable;
        logic              write_enable;
        csr_op_e           operation;
        logic [WORD_W-1:0] data;
    } csr_req_t;

    typedef struct packed {
        logic      raise_exception;
        logic      machine_return;
        logic      interrupt_ack;
        exc_code_e exception_code;
    } trap_t;

endpackage

`default_nettype wire

// ==== alu/exec_lsu.sv ====
// Load/store request former, purely combinational
// Only word-aligned addresses leave this block, the offset selects byte lanes
// Misaligned halfword or word accesses are not detected here
`timescale 1ns/1ps
`default_nettype none

module exec_lsu (
    input  exec_pkg::op_e                  op_i,
    input  logic [exec_pkg::WORD_W-1:0]    sum_i,
    input  logic [exec_pkg::WORD_W-1:0]    store_data_i,
    output exec_pkg::mem_req_t             mem_o
);

    always_comb begin
        mem_o.address     = {sum_i[exec_pkg::WORD_W-1:2], 2'b00};
        mem_o.read_enable = op_i inside {exec_pkg::LB, exec_pkg::LBU, exec_pkg::LH,
                                         exec_pkg::LHU, exec_pkg::LW};
    end

    // Replicate narrow store data over all lanes
    always_comb begin
        unique case (op_i)
            exec_pkg::SB: mem_o.write_data = {4{store_data_i[7:0]}};
            exec_pkg::SH: mem_o.write_data = {2{store_data_i[15:0]}};
            default:      mem_o.write_data = store_data_i;
        endcase
    end

    // Byte lanes from the address offset
    always_comb begin
        unique case (op_i)
            exec_pkg::SB: begin
                unique case (sum_i[1:0])
                    2'b11:   mem_o.write_enable = 4'b1000;
                    2'b10:   mem_o.write_enable = 4'b0100;
                    2'b01:   mem_o.write_enable = 4'b0010;
                    default: mem_o.write_enable = 4'b0001;
                endcase
            end
            exec_pkg::SH: mem_o.write_enable = sum_i[1] ? 4'b1100 : 4'b0011;
            exec_pkg::SW: mem_o.write_enable = 4'b1111;
            default:      mem_o.write_enable = 4'b0000;
        endcase
    end

endmodule

`default_nettype wire

// ==== alu/exec_alu.sv ====
// Integer ALU and branch unit, single cycle, no internal state
// The memory request is not gated by the kill level, the commit stage
// and the bus side are expected to ignore killed requests
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    input  exec_pkg::exec_in_t              instr_i,
    input  logic                            killed_i,
    output logic [exec_pkg::WORD_W-1:0]     result_o,
    output logic                            jump_o,
    output logic [exec_pkg::WORD_W-1:0]     jump_target_o,
    output exec_pkg::mem_req_t              mem_o
);

    exec_pkg::op_e               op;
    logic [exec_pkg::WORD_W-1:0] op_a;
    logic [exec_pkg::WORD_W-1:0] op_b;
    logic [exec_pkg::WORD_W-1:0] sum;
    logic [exec_pkg::WORD_W-1:0] sum2_a;
    logic [exec_pkg::WORD_W-1:0] sum2_b;
    logic [exec_pkg::WORD_W-1:0] sum2;
    logic                        equal;
    logic                        less_than;
    logic                        less_than_u;
    logic                        take;

    assign op   = instr_i.op;
    assign op_a = instr_i.first_operand;
    assign op_b = instr_i.second_operand;

    //////////////////////////////////////////////////////////////////////
    // Adders and compares
    //////////////////////////////////////////////////////////////////////

    assign sum         = op_a + op_b;
    assign equal       = op_a == op_b;
    assign less_than   = $signed(op_a) < $signed(op_b);
    assign less_than_u = op_a < op_b;

    // Second adder serves link address, SUB and branch target
    always_comb begin
        sum2_a = (op == exec_pkg::SUB) ? op_a : instr_i.pc;
        unique case (op)
            exec_pkg::JAL, exec_pkg::JALR:
                sum2_b = instr_i.compressed ? exec_pkg::LINK_STEP_COMPRESSED
                                            : exec_pkg::LINK_STEP_FULL;
            exec_pkg::SUB: sum2_b = -op_b;
            default:       sum2_b = instr_i.third_operand;
        endcase
    end

    assign sum2 = sum2_a + sum2_b;

    always_comb begin
        unique case (op)
            exec_pkg::JAL, exec_pkg::JALR,
            exec_pkg::SUB:  result_o = sum2;
            exec_pkg::SLT:  result_o = {31'b0, less_than};
            exec_pkg::SLTU: result_o = {31'b0, less_than_u};
            exec_pkg::AND:  result_o = op_a & op_b;
            exec_pkg::OR:   result_o = op_a | op_b;
            exec_pkg::XOR:  result_o = op_a ^ op_b;
            exec_pkg::SLL:  result_o = op_a << op_b[4:0];
            exec_pkg::SRL:  result_o = op_a >> op_b[4:0];
            exec_pkg::SRA:  result_o = $signed(op_a) >>> op_b[4:0];
            exec_pkg::LUI:  result_o = op_b;
            default:        result_o = sum;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Branch decision
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        unique case (op)
            exec_pkg::BEQ:  take = equal;
            exec_pkg::BNE:  take = ~equal;
            exec_pkg::BLT:  take = less_than;
            exec_pkg::BLTU: take = less_than_u;
            exec_pkg::BGE:  take = ~less_than;
            exec_pkg::BGEU: take = ~less_than_u;
            exec_pkg::JAL, exec_pkg::JALR: take = 1'b1;
            default:        take = 1'b0;
        endcase
    end

    assign jump_o = take & ~killed_i;

    always_comb begin
        unique case (op)
            exec_pkg::JALR: jump_target_o = {sum[exec_pkg::WORD_W-1:1], 1'b0};
            exec_pkg::JAL:  jump_target_o = sum;
            default:        jump_target_o = sum2;
        endcase
    end

    exec_lsu u_lsu (
        .op_i         (op),
        .sum_i        (sum),
        .store_data_i (instr_i.third_operand),
        .mem_o        (mem_o)
    );

endmodule

`default_nettype wire

// ==== system/exec_system.sv ====
// CSR request generation and trap priority, purely combinational
// CSR address, rd and rs1 are taken from the raw instruction word
// Only USER and MACHINE privilege levels are modelled
`timescale 1ns/1ps
`default_nettype none

module exec_system (
    input  exec_pkg::exec_in_t    instr_i,
    input  exec_pkg::priv_e       privilege_i,
    input  logic                  exc_illegal_i,
    input  logic                  exc_misaligned_fetch_i,
    input  logic                  exc_inst_access_fault_i,
    input  logic                  exc_load_access_fault_i,
    input  logic                  interrupt_pending_i,
    input  logic                  killed_i,
    output exec_pkg::csr_req_t    csr_o,
    output exec_pkg::trap_t       trap_o
);

    exec_pkg::op_e op;
    logic [4:0]    rd;
    logic [4:0]    rs1;
    logic [11:0]   csr_addr;
    logic          csr_read;
    logic          csr_write;
    logic          illegal_csr;
    logic          mem_op;

    assign op       = instr_i.op;
    assign rd       = instr_i.instruction[11:7];
    assign rs1      = instr_i.instruction[19:15];
    assign csr_addr = instr_i.instruction[31:20];
    assign mem_op   = op inside {exec_pkg::LB, exec_pkg::LBU, exec_pkg::LH, exec_pkg::LHU,
                                 exec_pkg::LW, exec_pkg::SB, exec_pkg::SH, exec_pkg::SW};

    //////////////////////////////////////////////////////////////////////
    // CSR access
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        csr_read  = 1'b0;
        csr_write = 1'b0;
        csr_o.operation = exec_pkg::NONE;
        unique case (op)
            exec_pkg::CSRRW, exec_pkg::CSRRWI: begin
                csr_read  = rd != '0;
                csr_write = 1'b1;
                csr_o.operation = exec_pkg::WRITE;
            end
            exec_pkg::CSRRS, exec_pkg::CSRRSI: begin
                csr_read  = 1'b1;
                csr_write = rs1 != '0;
                csr_o.operation = exec_pkg::SET;
            end
            exec_pkg::CSRRC, exec_pkg::CSRRCI: begin
                csr_read  = 1'b1;
                csr_write = rs1 != '0;
                csr_o.operation = exec_pkg::CLEAR;
            end
            default: ;
        endcase
    end

    // Read-only space is 11:10 == 3, privilege lives in bits 9:8
    assign illegal_csr = (csr_write && csr_addr[11:10] == 2'b11)
                       || ((csr_read || csr_write) && csr_addr[9:8] > privilege_i);

    assign csr_o.address      = csr_addr;
    assign csr_o.read_enable  = csr_read & ~illegal_csr;
    assign csr_o.write_enable = csr_write & ~illegal_csr;
    assign csr_o.data = (op inside {exec_pkg::CSRRW, exec_pkg::CSRRS, exec_pkg::CSRRC})
                      ? instr_i.first_operand : {27'b0, rs1};

    //////////////////////////////////////////////////////////////////////
    // Trap priority chain
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        trap_o.raise_exception = 1'b0;
        trap_o.machine_return  = 1'b0;
        trap_o.interrupt_ack   = 1'b0;
        trap_o.exception_code  = exec_pkg::NE;
        if (!killed_i) begin
            trap_o.raise_exception = 1'b1;
            if (exc_inst_access_fault_i) begin
                trap_o.exception_code = exec_pkg::INSTRUCTION_ACCESS_FAULT;
            end else if (exc_illegal_i || illegal_csr) begin
                trap_o.exception_code = exec_pkg::ILLEGAL_INSTRUCTION;
            end else if (exc_misaligned_fetch_i) begin
                trap_o.exception_code = exec_pkg::INSTRUCTION_ADDRESS_MISALIGNED;
            end else if (op == exec_pkg::ECALL) begin
                trap_o.exception_code = (privilege_i == exec_pkg::USER)
                                      ? exec_pkg::ECALL_FROM_UMODE : exec_pkg::ECALL_FROM_MMODE;
            end else if (op == exec_pkg::EBREAK) begin
                trap_o.exception_code = exec_pkg::BREAKPOINT;
            end else if (exc_load_access_fault_i && mem_op) begin
                trap_o.exception_code = exec_pkg::LOAD_ACCESS_FAULT;
            end else begin
                // No exception, MRET and interrupt remain
                trap_o.raise_exception = 1'b0;
                trap_o.machine_return  = op == exec_pkg::MRET;
                trap_o.interrupt_ack   = interrupt_pending_i && op != exec_pkg::MRET
                                         && op != exec_pkg::NOP;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/exec_commit.sv ====
// Write-back registers and tag based kill logic
// The tag advances once per jump or trap event, later instructions carrying
// the old tag are killed until the front end catches up
`timescale 1ns/1ps
`default_nettype none

module exec_commit #(
    parameter int TAG_W = 3
) (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            sys_reset_i,
    input  logic                            stall_i,
    input  logic [TAG_W-1:0]                tag_i,
    input  exec_pkg::op_e                   op_i,
    input  logic [exec_pkg::WORD_W-1:0]     alu_result_i,
    input  logic [exec_pkg::WORD_W-1:0]     csr_read_data_i,
    input  exec_pkg::trap_t                 trap_i,
    input  logic                            jump_i,
    output logic                            killed_o,
    output logic                            write_enable_o,
    output exec_pkg::op_e                   op_o,
    output logic [exec_pkg::WORD_W-1:0]     result_o
);

    logic [TAG_W-1:0]            curr_tag;
    logic [exec_pkg::WORD_W-1:0] result;
    logic                        write_enable;

    assign killed_o = (curr_tag != tag_i) | sys_reset_i;

    always_comb begin
        unique case (op_i)
            exec_pkg::CSRRW, exec_pkg::CSRRS, exec_pkg::CSRRC,
            exec_pkg::CSRRWI, exec_pkg::CSRRSI, exec_pkg::CSRRCI:
                result = csr_read_data_i;
            default:
                result = alu_result_i;
        endcase
    end

    // Stores and branches never write a register
    always_comb begin
        unique case (op_i)
            exec_pkg::NOP, exec_pkg::SB, exec_pkg::SH, exec_pkg::SW,
            exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::BLT, exec_pkg::BLTU,
            exec_pkg::BGE, exec_pkg::BGEU:
                write_enable = 1'b0;
            default:
                write_enable = ~(killed_o | trap_i.raise_exception);
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            write_enable_o <= 1'b0;
            op_o           <= exec_pkg::NOP;
            result_o       <= '0;
        end else if (!stall_i) begin
            write_enable_o <= write_enable;
            op_o           <= op_i;
            result_o       <= result;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            curr_tag <= '0;
        end else if (jump_i || trap_i.raise_exception || trap_i.machine_return
                     || trap_i.interrupt_ack) begin
            curr_tag <= curr_tag + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/execute_top.sv ====
// Execute stage top level, ALU and system blocks side by side
// Memory, CSR, jump and trap outputs are combinational from the inputs
// Result, write enable and operation are registered and hold under stall
`timescale 1ns/1ps
`default_nettype none

module execute_top #(
    parameter int TAG_W = 3
) (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            sys_reset_i,
    input  logic                            stall_i,
    input  logic [TAG_W-1:0]                tag_i,
    input  exec_pkg::exec_in_t              instr_i,
    input  exec_pkg::priv_e                 privilege_i,
    input  logic                            exc_illegal_i,
    input  logic                            exc_misaligned_fetch_i,
    input  logic                            exc_inst_access_fault_i,
    input  logic                            exc_load_access_fault_i,
    input  logic                            interrupt_pending_i,
    input  logic [exec_pkg::WORD_W-1:0]     csr_read_data_i,
    output logic                            killed_o,
    output logic                            jump_o,
    output logic [exec_pkg::WORD_W-1:0]     jump_target_o,
    output exec_pkg::mem_req_t              mem_o,
    output exec_pkg::csr_req_t              csr_o,
    output exec_pkg::trap_t                 trap_o,
    output logic                            write_enable_o,
    output exec_pkg::op_e                   op_o,
    output logic [exec_pkg::WORD_W-1:0]     result_o
);

    logic [exec_pkg::WORD_W-1:0] alu_result;

    exec_alu u_alu (
        .instr_i       (instr_i),
        .killed_i      (killed_o),
        .result_o      (alu_result),
        .jump_o        (jump_o),
        .jump_target_o (jump_target_o),
        .mem_o         (mem_o)
    );

    exec_system u_system (
        .instr_i                 (instr_i),
        .privilege_i             (privilege_i),
        .exc_illegal_i           (exc_illegal_i),
        .exc_misaligned_fetch_i  (exc_misaligned_fetch_i),
        .exc_inst_access_fault_i (exc_inst_access_fault_i),
        .exc_load_access_fault_i (exc_load_access_fault_i),
        .interrupt_pending_i     (interrupt_pending_i),
        .killed_i                (killed_o),
        .csr_o                   (csr_o),
        .trap_o                  (trap_o)
    );

    exec_commit #(
        .TAG_W (TAG_W)
    ) u_commit (
        .clk             (clk),
        .reset_n         (reset_n),
        .sys_reset_i     (sys_reset_i),
        .stall_i         (stall_i),
        .tag_i           (tag_i),
        .op_i            (instr_i.op),
        .alu_result_i    (alu_result),
        .csr_read_data_i (csr_read_data_i),
        .trap_i          (trap_o),
        .jump_i          (jump_o),
        .killed_o        (killed_o),
        .write_enable_o  (write_enable_o),
        .op_o            (op_o),
        .result_o        (result_o)
    );

endmodule

`default_nettype wire

// ==== testbench/execute_asserts.sv ====
// Concurrent checks on the execute stage outputs, bound to execute_top
// Sampled on the rising clock edge, disabled during reset
`timescale 1ns/1ps
`default_nettype none

module execute_asserts (
    input logic                 clk,
    input logic                 reset_n,
    input logic                 stall_i,
    input logic                 killed_o,
    input logic                 jump_o,
    input logic                 write_enable_o,
    input exec_pkg::trap_t      trap_o,
    input exec_pkg::mem_req_t   mem_o
);

    // A killed instruction has no side effects
    assert property (@(posedge clk) disable iff (!reset_n)
        killed_o |-> !jump_o && !trap_o.raise_exception && !trap_o.machine_return
                     && !trap_o.interrupt_ack)
        else $error("killed instruction produced a strobe");

    assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0({trap_o.raise_exception, trap_o.machine_return, trap_o.interrupt_ack}))
        else $error("more than one trap strobe");

    // A store never writes a register
    assert property (@(posedge clk) disable iff (!reset_n)
        (mem_o.write_enable != 4'b0000 && !stall_i) |=> !write_enable_o)
        else $error("store wrote back a register");

endmodule

bind execute_top execute_asserts u_asserts (
    .clk(clk), .reset_n(reset_n), .stall_i(stall_i), .killed_o(killed_o),
    .jump_o(jump_o), .write_enable_o(write_enable_o), .trap_o(trap_o), .mem_o(mem_o)
);

`default_nettype wire

// ==== testbench/tb_execute.sv ====
// Table-driven testbench for the execute stage, TAG_W fixed at 3
// Rows are driven 10 ns after the rising edge, combinational outputs are
// sampled just before the next edge and registered outputs 10 ns after it
`timescale 1ns/1ps
`default_nettype none

module tb_execute;

    typedef struct {
        exec_pkg::op_e      op;
        logic [31:0]        a, b, c, pc, instr, csr_rd;
        logic               comp;
        exec_pkg::priv_e    priv;
        logic [3:0]         exc;        // iaf, illegal, misfetch, laf
        logic               irq, stale, stall;
        logic [31:0]        exp_res, exp_target;
        logic               exp_we, exp_jump;
        exec_pkg::trap_t    exp_trap;
        logic               chk_mem, chk_csr;
        exec_pkg::mem_req_t exp_mem;
        exec_pkg::csr_req_t exp_csr;
    } row_t;

    localparam exec_pkg::trap_t NO_TRAP = '{1'b0, 1'b0, 1'b0, exec_pkg::NE};

    logic clk = 1'b0;
    logic reset_n = 1'b0;
    logic sys_reset = 1'b0;
    logic stall = 1'b0;
    logic [2:0] tag = '0;
    exec_pkg::exec_in_t instr = '0;
    exec_pkg::priv_e privilege = exec_pkg::MACHINE;
    logic exc_illegal = 1'b0;
    logic exc_misfetch = 1'b0;
    logic exc_iaf = 1'b0;
    logic exc_laf = 1'b0;
    logic irq = 1'b0;
    logic [31:0] csr_rd = '0;
    logic killed, jump, we;
    logic [31:0] target, result;
    exec_pkg::mem_req_t mem;
    exec_pkg::csr_req_t csr;
    exec_pkg::trap_t trap;
    exec_pkg::op_e op_out;

    row_t rows [0:63];
    int n = 0;
    int errors = 0;

    execute_top #(.TAG_W(3)) dut (
        .clk(clk), .reset_n(reset_n), .sys_reset_i(sys_reset), .stall_i(stall),
        .tag_i(tag), .instr_i(instr), .privilege_i(privilege),
        .exc_illegal_i(exc_illegal), .exc_misaligned_fetch_i(exc_misfetch),
        .exc_inst_access_fault_i(exc_iaf), .exc_load_access_fault_i(exc_laf),
        .interrupt_pending_i(irq), .csr_read_data_i(csr_rd),
        .killed_o(killed), .jump_o(jump), .jump_target_o(target), .mem_o(mem),
        .csr_o(csr), .trap_o(trap), .write_enable_o(we), .op_o(op_out),
        .result_o(result)
    );

    always #50 clk = ~clk;

    task automatic add_row(exec_pkg::op_e op, logic [31:0] a, logic [31:0] b,
                           logic [31:0] c, logic [31:0] res, logic w);
        rows[n] = '{op: op, a: a, b: b, c: c, pc: 32'h100, instr: '0, csr_rd: '0,
                    comp: 1'b0, priv: exec_pkg::MACHINE, exc: '0, irq: 1'b0,
                    stale: 1'b0, stall: 1'b0, exp_res: res, exp_target: '0,
                    exp_we: w, exp_jump: 1'b0, exp_trap: NO_TRAP, chk_mem: 1'b0,
                    chk_csr: 1'b0, exp_mem: '0, exp_csr: '0};
        n++;
    endtask

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_mem(exec_pkg::mem_req_t got, exec_pkg::mem_req_t exp);
        if (got !== exp) begin
            $display("ERR mem_o got %h exp %h", got, exp);
            errors++;
        end
    endtask

    task automatic check_csr(exec_pkg::csr_req_t got, exec_pkg::csr_req_t exp);
        if (got !== exp) begin
            $display("ERR csr_o got %h exp %h", got, exp);
            errors++;
        end
    endtask

    task automatic check_trap(exec_pkg::trap_t got, exec_pkg::trap_t exp);
        if (got !== exp) begin
            $display("ERR trap_o got %h exp %h", got, exp);
            errors++;
        end
    endtask

    task automatic fill_table();
        add_row(exec_pkg::ADD, 32'h5, 32'h7, 0, 32'hc, 1);
        add_row(exec_pkg::SUB, 32'h3, 32'h5, 0, 32'hffff_fffe, 1);
        add_row(exec_pkg::AND, 32'hf0f0, 32'hff00, 0, 32'hf000, 1);
        add_row(exec_pkg::OR, 32'hf0f0, 32'hff00, 0, 32'hfff0, 1);
        add_row(exec_pkg::XOR, 32'hf0f0, 32'hff00, 0, 32'h0ff0, 1);
        add_row(exec_pkg::SLL, 32'h1, 32'h4, 0, 32'h10, 1);
        add_row(exec_pkg::SRL, 32'h8000_0000, 32'h4, 0, 32'h0800_0000, 1);
        add_row(exec_pkg::SRA, 32'h8000_0000, 32'h4, 0, 32'hf800_0000, 1);
        add_row(exec_pkg::SLT, 32'hffff_ffff, 32'h1, 0, 32'h1, 1);
        add_row(exec_pkg::SLTU, 32'hffff_ffff, 32'h1, 0, 32'h0, 1);
        add_row(exec_pkg::LUI, 32'h0, 32'h1234_5000, 0, 32'h1234_5000, 1);
        // Branches, target is pc plus third operand
        add_row(exec_pkg::BEQ, 32'h3, 32'h3, 32'h20, 32'h6, 0);
        rows[n-1].exp_jump = 1'b1;
        rows[n-1].exp_target = 32'h120;
        add_row(exec_pkg::BNE, 32'h3, 32'h3, 32'h20, 32'h6, 0);
        add_row(exec_pkg::BLT, 32'hffff_ffff, 32'h1, 32'h10, 32'h0, 0);
        rows[n-1].exp_jump = 1'b1;
        rows[n-1].exp_target = 32'h110;
        add_row(exec_pkg::BGEU, 32'hffff_ffff, 32'h1, 32'h8, 32'h0, 0);
        rows[n-1].exp_jump = 1'b1;
        rows[n-1].exp_target = 32'h108;
        add_row(exec_pkg::JAL, 32'h100, 32'h40, 0, 32'h104, 1);
        rows[n-1].exp_jump = 1'b1;
        rows[n-1].exp_target = 32'h140;
        add_row(exec_pkg::JALR, 32'h201, 32'h10, 0, 32'h102, 1);
        rows[n-1].comp = 1'b1;
        rows[n-1].exp_jump = 1'b1;
        rows[n-1].exp_target = 32'h210;
        // Old tag after the jumps is killed, the next row runs
        add_row(exec_pkg::ADD, 32'h1, 32'h1, 0, 32'h2, 0);
        rows[n-1].stale = 1'b1;
        add_row(exec_pkg::ADD, 32'h2, 32'h2, 0, 32'h4, 1);
        // Loads and stores
        add_row(exec_pkg::LW, 32'h1003, 32'h1, 32'haabb_ccdd, 32'h1004, 1);
        rows[n-1].chk_mem = 1'b1;
        rows[n-1].exp_mem = '{32'h1004, 1'b1, 4'b0000, 32'haabb_ccdd};
        add_row(exec_pkg::SB, 32'h2000, 32'h2, 32'h55, 32'h2002, 0);
        rows[n-1].chk_mem = 1'b1;
        rows[n-1].exp_mem = '{32'h2000, 1'b0, 4'b0100, 32'h5555_5555};
        add_row(exec_pkg::SH, 32'h2000, 32'h3, 32'h1234, 32'h2003, 0);
        rows[n-1].chk_mem = 1'b1;
        rows[n-1].exp_mem = '{32'h2000, 1'b0, 4'b1100, 32'h1234_1234};
        add_row(exec_pkg::SW, 32'h10, 32'h0, 32'hdead_beef, 32'h10, 0);
        rows[n-1].chk_mem = 1'b1;
        rows[n-1].exp_mem = '{32'h10, 1'b0, 4'b1111, 32'hdead_beef};
        // CSR accesses, instruction word carries address, rs1 and rd
        add_row(exec_pkg::CSRRW, 32'hcafe, 0, 0, 32'h77, 1);
        rows[n-1].instr = 32'h3400_8000;
        rows[n-1].csr_rd = 32'h77;
        rows[n-1].chk_csr = 1'b1;
        rows[n-1].exp_csr = '{12'h340, 1'b0, 1'b1, exec_pkg::WRITE, 32'hcafe};
        add_row(exec_pkg::CSRRSI, 0, 0, 0, 32'h1800, 1);
        rows[n-1].instr = 32'h3000_0280;
        rows[n-1].csr_rd = 32'h1800;
        rows[n-1].chk_csr = 1'b1;
        rows[n-1].exp_csr = '{12'h300, 1'b1, 1'b0, exec_pkg::SET, 32'h0};
        add_row(exec_pkg::CSRRC, 32'hf, 0, 0, 32'h99, 1);
        rows[n-1].instr = 32'h3051_0080;
        rows[n-1].csr_rd = 32'h99;
        rows[n-1].chk_csr = 1'b1;
        rows[n-1].exp_csr = '{12'h305, 1'b1, 1'b1, exec_pkg::CLEAR, 32'hf};
        add_row(exec_pkg::CSRRW, 32'h1, 0, 0, 32'h5, 0);
        rows[n-1].instr = 32'hc000_8080;
        rows[n-1].csr_rd = 32'h5;
        rows[n-1].chk_csr = 1'b1;
        rows[n-1].exp_csr = '{12'hc00, 1'b0, 1'b0, exec_pkg::WRITE, 32'h1};
        rows[n-1].exp_trap = '{1'b1, 1'b0, 1'b0, exec_pkg::ILLEGAL_INSTRUCTION};
        add_row(exec_pkg::CSRRS, 32'h0, 0, 0, 32'h0, 0);
        rows[n-1].instr = 32'h3000_0080;
        rows[n-1].priv = exec_pkg::USER;
        rows[n-1].chk_csr = 1'b1;
        rows[n-1].exp_csr = '{12'h300, 1'b0, 1'b0, exec_pkg::SET, 32'h0};
        rows[n-1].exp_trap = '{1'b1, 1'b0, 1'b0, exec_pkg::ILLEGAL_INSTRUCTION};
        // Trap priority
        add_row(exec_pkg::ADD, 32'h1, 32'h1, 0, 32'h2, 0);
        rows[n-1].exc = 4'b1110;
        rows[n-1].exp_trap = '{1'b1, 1'b0, 1'b0, exec_pkg::INSTRUCTION_ACCESS_FAULT};
        add_row(exec_pkg::ADD, 0, 0, 0, 0, 0);
        rows[n-1].exc = 4'b0110;
        rows[n-1].exp_trap = '{1'b1, 1'b0, 1'b0, exec_pkg::ILLEGAL_INSTRUCTION};
        add_row(exec_pkg::ECALL, 0, 0, 0, 0, 0);
        rows[n-1].exc = 4'b0010;
        rows[n-1].exp_trap = '{1'b1, 1'b0, 1'b0, exec_pkg::INSTRUCTION_ADDRESS_MISALIGNED};
        add_row(exec_pkg::ECALL, 0, 0, 0, 0, 0);
        rows[n-1].priv = exec_pkg::USER;
        rows[n-1].exp_trap = '{1'b1, 1'b0, 1'b0, exec_pkg::ECALL_FROM_UMODE};
        add_row(exec_pkg::ECALL, 0, 0, 0, 0, 0);
        rows[n-1].exp_trap = '{1'b1, 1'b0, 1'b0, exec_pkg::ECALL_FROM_MMODE};
        add_row(exec_pkg::EBREAK, 0, 0, 0, 0, 0);
        rows[n-1].exc = 4'b0001;
        rows[n-1].exp_trap = '{1'b1, 1'b0, 1'b0, exec_pkg::BREAKPOINT};
        add_row(exec_pkg::LW, 32'h40, 0, 0, 32'h40, 0);
        rows[n-1].exc = 4'b0001;
        rows[n-1].exp_trap = '{1'b1, 1'b0, 1'b0, exec_pkg::LOAD_ACCESS_FAULT};
        add_row(exec_pkg::ADD, 32'h1, 32'h2, 0, 32'h3, 1);
        rows[n-1].exc = 4'b0001;
        add_row(exec_pkg::MRET, 0, 0, 0, 0, 1);
        rows[n-1].irq = 1'b1;
        rows[n-1].exp_trap = '{1'b0, 1'b1, 1'b0, exec_pkg::NE};
        add_row(exec_pkg::ADD, 32'h4, 32'h4, 0, 32'h8, 1);
        rows[n-1].irq = 1'b1;
        rows[n-1].exp_trap = '{1'b0, 1'b0, 1'b1, exec_pkg::NE};
        add_row(exec_pkg::ADD, 32'h8, 32'h8, 0, 32'h10, 0);
        rows[n-1].irq = 1'b1;
        rows[n-1].stale = 1'b1;
        // Stall holds the registered outputs of the row before
        add_row(exec_pkg::ADD, 32'h9, 32'h1, 0, 32'ha, 1);
        add_row(exec_pkg::ADD, 32'h50, 32'h0, 0, 32'h50, 1);
        rows[n-1].stall = 1'b1;
        rows[n-1].chk_mem = 1'b1;
        rows[n-1].exp_mem = '{32'h50, 1'b0, 4'b0000, 32'h0};
        add_row(exec_pkg::ADD, 32'h7, 32'h7, 0, 32'he, 1);
    endtask

    initial begin
        row_t r;
        logic [2:0] tag_model;
        logic [31:0] reg_res;
        logic reg_we;
        exec_pkg::op_e reg_op;
        int row_errs;
        int cycles;

        fill_table();
        tag_model = '0;
        reg_res = '0;
        reg_we = 1'b0;
        reg_op = exec_pkg::NOP;

        repeat (10) @(posedge clk);
        // Registered outputs must show their reset values before release
        cycles = 0;
        while ((we !== 1'b0 || op_out !== exec_pkg::NOP || result !== '0)
               && cycles < 50) begin
            @(posedge clk);
            cycles++;
        end
        if (we !== 1'b0 || op_out !== exec_pkg::NOP || result !== '0) begin
            $display("Registered outputs never reached their reset values");
            $display("Testbench failed");
            $finish;
        end else begin
            #10 reset_n = 1'b1;

            for (int i = 0; i < n; i++) begin
                r = rows[i];
                row_errs = errors;
                instr = '{r.op, r.pc, r.a, r.b, r.c, r.comp, r.instr};
                tag = r.stale ? tag_model - 3'd1 : tag_model;
                stall = r.stall;
                privilege = r.priv;
                {exc_iaf, exc_illegal, exc_misfetch, exc_laf} = r.exc;
                irq = r.irq;
                csr_rd = r.csr_rd;
                #80;
                check_word("killed_o", 32'(killed), 32'(r.stale));
                check_word("jump_o", 32'(jump), 32'(r.exp_jump));
                if (r.exp_jump)
                    check_word("jump_target_o", target, r.exp_target);
                check_trap(trap, r.exp_trap);
                if (r.chk_mem)
                    check_mem(mem, r.exp_mem);
                if (r.chk_csr)
                    check_csr(csr, r.exp_csr);
                if (!r.stall) begin
                    reg_res = r.exp_res;
                    reg_we = r.exp_we;
                    reg_op = r.op;
                end
                if (r.exp_jump || r.exp_trap.raise_exception || r.exp_trap.machine_return
                    || r.exp_trap.interrupt_ack)
                    tag_model = tag_model + 3'd1;
                @(posedge clk);
                #10;
                check_word("result_o", result, reg_res);
                check_word("write_enable_o", 32'(we), 32'(reg_we));
                check_word("op_o", 32'(op_out), 32'(reg_op));
                $display("row %0d %s %s", i, r.op.name(),
                         (errors == row_errs) ? "ok" : "mismatch");
            end

            $display("%0d rows, %0d errors", n, errors);
            if (errors == 0)
                $display("Testbench passed");
            else
                $display("Testbench failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
common/exec_pkg.sv
alu/exec_lsu.sv
alu/exec_alu.sv
system/exec_system.sv
rtl/exec_commit.sv
rtl/execute_top.sv
testbench/execute_asserts.sv
testbench/tb_execute.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_execute -o sim_execute > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_execute > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Testbench passed" sim.log; then
    exit 0
fi
exit 1
